/* Bender.yml */
package:
  name: icache

export_include_dirs:
  - rtl

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_refill_if.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_tag_array.sv
  - rtl/icache_data_array.sv
  - rtl/icache_inst_align.sv
  - rtl/icache_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/icache_props.sv
      - sim/icache_tb.sv

/* build.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_refill_if.sv
rtl/icache_ctrl.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_inst_align.sv
rtl/icache_top.sv
sim/tb_clk_gen.sv
sim/icache_props.sv
sim/icache_tb.sv

/* rtl/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// address width, also the width of one memory word
`define ICACHE_ADDR_W 32

// 128 lines of 64 bytes, 8 KB total
`define ICACHE_LINES 128
`define ICACHE_LINE_BYTES 64

// words per refill burst
// line bytes over word bytes
`define ICACHE_BURST_LEN 16

// top nibble of the uncached device window
`define ICACHE_IO_PREFIX 4'hA

// addi x0, x0, 0
`define ICACHE_NOP 32'h00000013

`endif

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_valid_i,
  input  icache_pkg::addr_t  fetch_addr_i,
  output logic               fetch_ready_o,
  output logic               fetch_done_o,
  input  logic               hit_i,
  output logic               mem_req_o,
  output icache_pkg::addr_t  mem_addr_o,
  output logic [7:0]         mem_len_o,
  input  logic               mem_rvalid_i,
  input  logic [31:0]        mem_rdata_i,
  output icache_pkg::addr_t  req_addr_o,
  output logic               uncached_o,
  output logic [31:0]        io_word_o,
  icache_refill_if.ctrl      refill
);
  import icache_pkg::*;

  icache_state_e state_q;
  addr_t req_addr_q;
  beat_t beat_q;
  logic done_q;
  logic io_hit;
  logic beat_ok;
  logic last_beat;
  logic accept;

  // one request at a time
  // ready only in IDLE and not while done is out
  assign fetch_ready_o = (state_q == IDLE) && !done_q;
  assign accept = fetch_valid_i && fetch_ready_o;
  assign fetch_done_o = done_q;

  // device window decided by the top nibble of the latched address
  assign io_hit = (req_addr_q[ADDR_W-1 -: 4] == `ICACHE_IO_PREFIX);
  assign uncached_o = io_hit;
  assign req_addr_o = req_addr_q;

  // a beat is any cycle with request and rvalid together
  assign beat_ok = mem_req_o && mem_rvalid_i;
  assign last_beat = beat_ok && (beat_q == beat_t'(`ICACHE_BURST_LEN - 1));

  // refill write port, only live in MISS
  assign refill.word_we = beat_ok && (state_q == MISS);
  assign refill.index = req_addr_q[OFF_W +: IDX_W];
  assign refill.beat = beat_q;
  assign refill.wdata = mem_rdata_i;
  // tag lands with the last word so the next LOOKUP hits
  assign refill.tag_we = last_beat && (state_q == MISS);
  assign refill.tag = req_addr_q[ADDR_W-1 -: TAG_W];

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RST;
      done_q <= 1'b0;
      mem_req_o <= 1'b0;
      beat_q <= '0;
    end else begin
      // done is a single-cycle strobe
      done_q <= 1'b0;
      case (state_q)
        RST: begin
          state_q <= IDLE;
        end
        IDLE: begin
          if (accept) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          // device window bypasses the tags entirely
          if (io_hit) begin
            state_q <= UNCACHE_READ;
            mem_req_o <= 1'b1;
          end else if (hit_i) begin
            state_q <= IDLE;
            done_q <= 1'b1;
          end else begin
            state_q <= MISS;
            mem_req_o <= 1'b1;
            beat_q <= '0;
          end
        end
        MISS: begin
          if (beat_ok) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              // line complete, retry the lookup
              mem_req_o <= 1'b0;
              state_q <= LOOKUP;
            end
          end
        end
        UNCACHE_READ: begin
          if (beat_ok) begin
            mem_req_o <= 1'b0;
            done_q <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // address latch and memory command, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q <= fetch_addr_i;
    end
    if (state_q == LOOKUP) begin
      if (io_hit) begin
        // single word, word aligned
        mem_addr_o <= {req_addr_q[ADDR_W-1:2], 2'b00};
        mem_len_o <= 8'd0;
      end else begin
        // whole line from its base
        mem_addr_o <= {req_addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        mem_len_o <= 8'(`ICACHE_BURST_LEN - 1);
      end
    end
    // keep the device word for the done cycle
    if ((state_q == UNCACHE_READ) && beat_ok) begin
      io_word_o <= mem_rdata_i;
    end
  end

endmodule

/* rtl/icache_data_array.sv */
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_data_array (
  input  logic               clk,
  input  icache_pkg::index_t rd_index_i,
  output icache_pkg::line_t  line_o,
  icache_refill_if.array     refill
);
  import icache_pkg::*;

  // word width in bits
  localparam int WORD_W = `ICACHE_ADDR_W;

  // line storage, no reset
  line_t lines_q [`ICACHE_LINES];

  // word slot position inside the line
  logic [$clog2(LINE_W)-1:0] wr_pos;

  // beat n goes to bits 32n+31:32n
  assign wr_pos = {refill.beat, {$clog2(WORD_W){1'b0}}};

  // one word per beat, rest of the line untouched
  always_ff @(posedge clk) begin
    if (refill.word_we) begin
      lines_q[refill.index][wr_pos +: WORD_W] <= refill.wdata;
    end
  end

  // whole line read, no clock
  assign line_o = lines_q[rd_index_i];

endmodule

/* rtl/icache_inst_align.sv */
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_inst_align (
  input  icache_pkg::line_t   line_i,
  input  icache_pkg::offset_t offset_i,
  input  logic                uncached_i,
  input  logic [31:0]         io_word_i,
  output logic [31:0]         inst_o
);
  import icache_pkg::*;

  // halfword number inside the line
  logic [OFF_W-2:0] hw_idx;
  logic [OFF_W-2:0] hw_next;
  logic [15:0] half_lo;
  logic [15:0] half_hi;
  logic last_half;
  logic is_32;
  logic [31:0] cached_inst;
  logic [31:0] sel_inst;

  // byte bit 0 ignored, fetch is halfword aligned
  assign hw_idx = offset_i[OFF_W-1:1];
  assign hw_next = hw_idx + 1'b1;
  assign last_half = &hw_idx;

  // first halfword of the instruction
  assign half_lo = line_i[{hw_idx, 4'b0000} +: 16];

  // second halfword, cut at the end of the line
  // no next-line fetch, so offset 62 gives zero here
  assign half_hi = last_half ? 16'h0000 : line_i[{hw_next, 4'b0000} +: 16];

  // RVC rule: low bits 11 means full width
  assign is_32 = (half_lo[1:0] == 2'b11);

  assign cached_inst = is_32 ? {half_hi, half_lo} : {16'h0000, half_lo};

  // device word bypasses extraction
  assign sel_inst = uncached_i ? io_word_i : cached_inst;

  // all-zero word turns into a nop
  assign inst_o = (sel_inst == 32'h0) ? `ICACHE_NOP : sel_inst;

endmodule

/* rtl/icache_pkg.sv */
`include "icache_cfg.svh"

package icache_pkg;

  // field widths derived from the geometry
  localparam int ADDR_W = `ICACHE_ADDR_W;
  localparam int IDX_W = $clog2(`ICACHE_LINES);
  localparam int OFF_W = $clog2(`ICACHE_LINE_BYTES);
  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;
  localparam int BEAT_W = $clog2(`ICACHE_BURST_LEN);
  localparam int LINE_W = `ICACHE_LINE_BYTES * 8;

  // address split is {tag, index, offset}
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] index_t;
  typedef logic [OFF_W-1:0] offset_t;

  // word number inside a line
  typedef logic [BEAT_W-1:0] beat_t;

  // one whole line, word 0 in the low bits
  typedef logic [LINE_W-1:0] line_t;

  // fetch controller states
  typedef enum logic [2:0] {
    RST,
    IDLE,
    LOOKUP,
    MISS,
    UNCACHE_READ
  } icache_state_e;

endpackage

/* rtl/icache_refill_if.sv */
`timescale 1ns/1ns

interface icache_refill_if;
  import icache_pkg::*;

  // one strobe per accepted memory beat
  logic word_we;
  // line under refill and word slot within it
  index_t index;
  beat_t beat;
  logic [31:0] wdata;
  // tag update on the final beat only
  logic tag_we;
  tag_t tag;

  // controller side drives everything
  modport ctrl (
    output word_we, index, beat, wdata, tag_we, tag
  );

  // tag and data arrays only listen
  modport array (
    input word_we, index, beat, wdata, tag_we, tag
  );

endinterface

/* rtl/icache_tag_array.sv */
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_tag_array (
  input  logic               clk,
  input  logic               rst,
  input  icache_pkg::index_t lookup_index_i,
  input  icache_pkg::tag_t   lookup_tag_i,
  output logic               hit_o,
  icache_refill_if.array     refill
);
  import icache_pkg::*;

  // one valid bit per line, cleared by reset
  logic [`ICACHE_LINES-1:0] valid_q;
  // stored tags, meaningless until valid
  tag_t tags_q [`ICACHE_LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (refill.tag_we) begin
      valid_q[refill.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refill.tag_we) begin
      tags_q[refill.index] <= refill.tag;
    end
  end

  // combinational compare against the latched request
  assign hit_o = valid_q[lookup_index_i] && (tags_q[lookup_index_i] == lookup_tag_i);

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ns

module icache_top (
  input  logic              clk,
  input  logic              rst,
  // fetch side
  input  logic              fetch_valid_i,
  input  icache_pkg::addr_t fetch_addr_i,
  output logic              fetch_ready_o,
  output logic              fetch_done_o,
  output logic [31:0]       fetch_inst_o,
  // memory side
  output logic              mem_req_o,
  output icache_pkg::addr_t mem_addr_o,
  output logic [7:0]        mem_len_o,
  input  logic              mem_rvalid_i,
  input  logic [31:0]       mem_rdata_i
);
  import icache_pkg::*;

  // refill path shared by both arrays
  icache_refill_if refill ();

  addr_t req_addr;
  logic hit;
  logic uncached;
  logic [31:0] io_word;
  line_t line;

  icache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_done_o  (fetch_done_o),
    .hit_i         (hit),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_len_o     (mem_len_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .req_addr_o    (req_addr),
    .uncached_o    (uncached),
    .io_word_o     (io_word),
    .refill        (refill.ctrl)
  );

  // lookup with the latched tag and index
  icache_tag_array u_tag (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (req_addr[OFF_W +: IDX_W]),
    .lookup_tag_i   (req_addr[ADDR_W-1 -: TAG_W]),
    .hit_o          (hit),
    .refill         (refill.array)
  );

  icache_data_array u_data (
    .clk        (clk),
    .rd_index_i (req_addr[OFF_W +: IDX_W]),
    .line_o     (line),
    .refill     (refill.array)
  );

  // instruction out of the indexed line
  icache_inst_align u_align (
    .line_i     (line),
    .offset_i   (req_addr[OFF_W-1:0]),
    .uncached_i (uncached),
    .io_word_i  (io_word),
    .inst_o     (fetch_inst_o)
  );

endmodule

/* sim/icache_props.sv */
`timescale 1ns/1ns

module icache_props (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_req_i,
  input  icache_pkg::addr_t mem_addr_i,
  input  logic [7:0]        mem_len_i,
  input  logic              mem_rvalid_i,
  input  logic              fetch_ready_i,
  input  logic              fetch_done_i,
  input  logic              tag_we_i
);

  // beats seen in the current request
  logic [7:0] beats_q;
  logic beat;
  logic final_beat;
  // read by the testbench
  int fail_total = 0;

  assign beat = mem_req_i && mem_rvalid_i;
  // last beat is number mem_len of the burst
  assign final_beat = beat && (beats_q == mem_len_i);

  always_ff @(posedge clk) begin
    if (rst || !mem_req_i) begin
      beats_q <= '0;
    end else if (mem_rvalid_i) begin
      beats_q <= beats_q + 1'b1;
    end
  end

  // request and address held until the burst is complete
  req_held: assert property (@(posedge clk) disable iff (rst)
    (mem_req_i && !final_beat) |=> (mem_req_i && $stable(mem_addr_i)))
  else begin
    fail_total++;
    $error("memory request dropped or address moved before the last beat");
  end

  // done only follows a busy cycle, never straight out of a ready one
  done_not_ready: assert property (@(posedge clk) disable iff (rst)
    fetch_done_i |-> !$past(fetch_ready_i))
  else begin
    fail_total++;
    $error("fetch done raised right after a cycle with the cache ready");
  end

  // tag written with the final refill beat
  tag_on_beat: assert property (@(posedge clk) disable iff (rst)
    tag_we_i |-> final_beat)
  else begin
    fail_total++;
    $error("tag write without a final memory beat");
  end

endmodule

bind icache_ctrl icache_props u_props (
  .clk           (clk),
  .rst           (rst),
  .mem_req_i     (mem_req_o),
  .mem_addr_i    (mem_addr_o),
  .mem_len_i     (mem_len_o),
  .mem_rvalid_i  (mem_rvalid_i),
  .fetch_ready_i (fetch_ready_o),
  .fetch_done_i  (fetch_done_o),
  .tag_we_i      (refill.tag_we)
);

/* sim/icache_tb.sv */
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_tb;
  import icache_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_FETCHES = 400;
  localparam int WORST_CYCLES = 60;
  localparam int NUM_RANDOM = 300;

  logic clk;
  logic rst;
  logic fetch_valid;
  addr_t fetch_addr;
  logic fetch_ready;
  logic fetch_done;
  logic [31:0] fetch_inst;
  logic mem_req;
  addr_t mem_addr;
  logic [7:0] mem_len;
  logic mem_rvalid;
  logic [31:0] mem_rdata;

  // memory model state
  logic [31:0] mem_seed;
  logic burst_active;
  addr_t burst_addr;
  int word_ptr;
  int req_count;
  addr_t last_req_addr;
  logic [7:0] last_req_len;
  int last_req_beats;

  // stimulus and scoreboard
  logic [31:0] stim_seed;
  addr_t expect_q[$];
  addr_t cmp_addr;

  tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

  icache_top UUT (
    .clk (clk), .rst (rst),
    .fetch_valid_i (fetch_valid), .fetch_addr_i (fetch_addr),
    .fetch_ready_o (fetch_ready), .fetch_done_o (fetch_done),
    .fetch_inst_o (fetch_inst),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_len_o (mem_len),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // memory content as a fixed function of the word address
  function automatic logic [31:0] mem_word(input addr_t a);
    logic [29:0] w;
    logic [31:0] x;
    w = a[31:2];
    x = {2'b00, w} * 32'h9E3779B1;
    x = x ^ (x >> 15);
    // one empty word in every 32
    if (w[4:0] == 5'd7) begin
      return 32'h0;
    end
    // low bits 11 or 01 in the low half, 11 or 10 in the high half
    return {x[31:18], (x[17] ? 2'b11 : 2'b10), x[15:2], (x[16] ? 2'b11 : 2'b01)};
  endfunction

  // expected instruction for a fetch address
  function automatic logic [31:0] ref_inst(input addr_t a);
    logic [31:0] word;
    logic [31:0] next_word;
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] r;
    word = mem_word({a[31:2], 2'b00});
    if (a[31:28] == `ICACHE_IO_PREFIX) begin
      r = word;
    end else begin
      lo = a[1] ? word[31:16] : word[15:0];
      hi = 16'h0000;
      if (lo[1:0] == 2'b11) begin
        // last halfword of a line has no upper half
        if (a[5:1] == 5'd31) begin
          hi = 16'h0000;
        end else if (a[1]) begin
          next_word = mem_word({a[31:2], 2'b00} + 32'd4);
          hi = next_word[15:0];
        end else begin
          hi = word[31:16];
        end
        r = {hi, lo};
      end else begin
        r = {16'h0000, lo};
      end
    end
    if (r == 32'h0) begin
      r = `ICACHE_NOP;
    end
    return r;
  endfunction

  function automatic logic wide_line_end(input addr_t base);
    logic [31:0] w;
    w = mem_word(base + 32'd60);
    return w[17:16] == 2'b11;
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one fetch entered and left just after a rising edge
  task automatic do_fetch(input addr_t a, output int cycles, output int reqs,
                          output logic [31:0] inst);
    int req_start;
    while (!fetch_ready) begin
      @(posedge clk);
      #1;
    end
    fetch_valid = 1'b1;
    fetch_addr = a;
    @(posedge clk);
    // accepting edge
    req_start = req_count;
    expect_q.push_back(a);
    #1;
    fetch_valid = 1'b0;
    // one fetch in flight, so ready drops at once
    compare_word("ready while busy", fetch_ready, 1'b0);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!fetch_done);
    inst = fetch_inst;
    reqs = req_count - req_start;
    #1;
  endtask

  // memory slave counts beats at the edge and drives 1 ns later
  always @(posedge clk) begin
    if (mem_req && mem_rvalid) begin
      word_ptr++;
      last_req_beats++;
    end
    #1;
    if (mem_req && !rst) begin
      if (!burst_active) begin
        burst_active = 1'b1;
        burst_addr = mem_addr;
        word_ptr = 0;
        req_count++;
        last_req_addr = mem_addr;
        last_req_len = mem_len;
        last_req_beats = 0;
      end
      mem_seed = lcg_step(mem_seed);
      // about one cycle in four stalls
      mem_rvalid = (mem_seed[17:16] != 2'b00);
      mem_rdata = mem_word(burst_addr + addr_t'(4 * word_ptr));
    end else begin
      burst_active = 1'b0;
      mem_rvalid = 1'b0;
      mem_rdata = 32'h0;
    end
  end

  // every done strobe against the reference
  always @(posedge clk) begin
    if (!rst && fetch_done) begin
      if (expect_q.size() == 0) begin
        $display("fetch done arrived at %0t ns with no fetch outstanding", $time);
        $display("RESULT: FAIL");
        $fatal(1, "unexpected done");
      end else begin
        cmp_addr = expect_q.pop_front();
        compare_word($sformatf("instruction at %h", cmp_addr), fetch_inst,
                     ref_inst(cmp_addr));
      end
    end
  end

  // bound assertion failures end the run at once
  always @(UUT.u_ctrl.u_props.fail_total) begin
    if (UUT.u_ctrl.u_props.fail_total > 0) begin
      $display("bound assertion failed at %0t ns", $time);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    #(MAX_FETCHES * WORST_CYCLES * CLK_PERIOD);
    $display("watchdog expired, fetches stopped completing");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    int cycles;
    int reqs;
    int k;
    logic [31:0] inst;
    logic found;
    addr_t a;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    mem_seed = 32'd3158;
    stim_seed = 32'd3158;
    burst_active = 1'b0;
    word_ptr = 0;
    req_count = 0;
    last_req_beats = 0;
    @(negedge rst);
    compare_word("done after reset", fetch_done, 1'b0);
    compare_word("mem request after reset", mem_req, 1'b0);
    // still in the reset state for one more cycle
    compare_word("ready after reset", fetch_ready, 1'b0);

    // cold miss with a full line burst
    do_fetch(32'h0000_0106, cycles, reqs, inst);
    compare_word("cold miss requests", reqs, 1);
    compare_word("cold miss burst address", last_req_addr, 32'h0000_0100);
    compare_word("cold miss burst length", last_req_len, 15);
    compare_word("cold miss beats", last_req_beats, `ICACHE_BURST_LEN);

    // hit in the same line at offset 62
    do_fetch(32'h0000_013E, cycles, reqs, inst);
    compare_word("hit latency", cycles, 2);
    compare_word("hit requests", reqs, 0);

    // a 32-bit opcode cut at the line end
    a = 32'h0000_0400;
    found = 1'b0;
    for (k = 0; k < 32 && !found; k++) begin
      if (wide_line_end(a)) begin
        found = 1'b1;
      end else begin
        a = a + 32'd64;
      end
    end
    compare_word("wide opcode at line end found", found, 1'b1);
    do_fetch(a + 32'd62, cycles, reqs, inst);
    compare_word("line end upper half", inst[31:16], 16'h0000);

    // two regions share indexes so lines get evicted
    for (k = 0; k < NUM_RANDOM; k++) begin
      stim_seed = lcg_step(stim_seed);
      a = (stim_seed[24] ? 32'h0000_3000 : 32'h0000_1000)
          | {23'd0, stim_seed[22:20], 6'd0}
          | {26'd0, stim_seed[30:26], 1'b0};
      do_fetch(a, cycles, reqs, inst);
      compare_word("random fetch at most one burst", reqs > 1, 1'b0);
    end

    // device window reads a single word and is never cached
    do_fetch(32'hA000_0046, cycles, reqs, inst);
    compare_word("io requests", reqs, 1);
    compare_word("io word address", last_req_addr, 32'hA000_0044);
    compare_word("io length", last_req_len, 0);
    compare_word("io beats", last_req_beats, 1);
    do_fetch(32'hA000_0046, cycles, reqs, inst);
    compare_word("io repeat requests", reqs, 1);

    // zero words come back as nop
    do_fetch(32'h0000_001C, cycles, reqs, inst);
    compare_word("cached zero word", inst, `ICACHE_NOP);
    do_fetch(32'hA000_001C, cycles, reqs, inst);
    compare_word("io zero word", inst, `ICACHE_NOP);

    if (UUT.u_ctrl.u_props.fail_total == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 40 ns period, first rising edge at 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // held over 5 rising edges, dropped just after the last one
  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule
